//--- rtl/icache_pkg.sv
package icache_pkg;

  // address and data widths
  localparam int ADDR_W = 32;
  localparam int XLEN   = 64; // cpu port and bus beat

  // address split: tag | index | offset
  localparam int TAG_W = 20;
  localparam int IDX_W = 6;
  localparam int OFS_W = 6;

  // cache geometry, 4 KB direct mapped
  localparam int NUM_LINES  = 64;
  localparam int LINE_BEATS = 8;   // 64-byte line in 64-bit beats

  // line storage, two beats per sram word
  localparam int BANK_W    = 128;
  localparam int NUM_BANKS = 4;

  // memory bus request encodings
  localparam logic [3:0] RSIZE_LINE = 4'b1000; // 64-bit beat
  localparam logic [3:0] RSIZE_WORD = 4'b0100; // 32-bit beat
  localparam logic [7:0] RLEN_LINE  = 8'd7;    // burst length minus one

  // everything below this address bypasses the cache
  localparam logic [ADDR_W-1:0] UNCACHE_LIMIT = 32'h8000_0000;

endpackage

//--- rtl/icache_tag.sv
module icache_tag (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [icache_pkg::TAG_W-1:0] tag_i,
  input  logic [icache_pkg::IDX_W-1:0] index_i,
  input  logic                        write_valid_i,
  input  logic                        fencei_i,
  output logic                        hit_o
);
  import icache_pkg::*;

  logic [TAG_W-1:0]     tags [NUM_LINES];
  logic [NUM_LINES-1:0] valid;

  // fence.i wins over a refill landing in the same cycle
  always_ff @(posedge clk) begin
    if (rst || fencei_i) begin
      valid <= '0;
    end else if (write_valid_i) begin
      valid[index_i] <= 1'b1;
    end
  end

  // tag is only meaningful once the valid bit is set
  always_ff @(posedge clk) begin
    if (write_valid_i) begin
      tags[index_i] <= tag_i;
    end
  end

  assign hit_o = valid[index_i] && (tags[index_i] == tag_i); // live lookup

endmodule

//--- rtl/icache_sram.sv
module icache_sram (
  input  logic                         clk,
  input  logic [icache_pkg::IDX_W-1:0]  addr_i,
  input  logic                         cen_i,
  input  logic                         wen_i,
  input  logic [icache_pkg::BANK_W-1:0] wmask_i,
  input  logic [icache_pkg::BANK_W-1:0] wdata_i,
  output logic [icache_pkg::BANK_W-1:0] rdata_o
);
  import icache_pkg::*;

  logic [BANK_W-1:0] mem [NUM_LINES];

  // single port: a write cycle leaves rdata_o unchanged
  always_ff @(posedge clk) begin
    if (cen_i && wen_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i); // bit mask merge
    end else if (cen_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

//--- rtl/icache_data.sv
module icache_data (
  input  logic                                                    clk,
  input  logic [icache_pkg::IDX_W-1:0]                             index_i,
  input  logic [icache_pkg::OFS_W-1:0]                             blk_ofs_i,
  input  logic [icache_pkg::XLEN-1:0]                              beat_i,
  input  logic [2:0]                                               beat_cnt_i,
  input  logic                                                    beat_wen_i,
  output logic [icache_pkg::XLEN-1:0]                              rdata_o,
  output logic [icache_pkg::NUM_BANKS-1:0][icache_pkg::IDX_W-1:0]  bank_addr_o,
  output logic [icache_pkg::NUM_BANKS-1:0]                         bank_cen_o,
  output logic [icache_pkg::NUM_BANKS-1:0]                         bank_wen_o,
  output logic [icache_pkg::NUM_BANKS-1:0][icache_pkg::BANK_W-1:0] bank_wmask_o,
  output logic [icache_pkg::NUM_BANKS-1:0][icache_pkg::BANK_W-1:0] bank_wdata_o,
  input  logic [icache_pkg::NUM_BANKS-1:0][icache_pkg::BANK_W-1:0] bank_rdata_i
);
  import icache_pkg::*;

  // refill write stage
  logic              wr_en;
  logic [XLEN-1:0]   wr_beat;
  logic [2:0]        wr_cnt;
  logic [BANK_W-1:0] wr_mask;

  // read side
  logic [BANK_W-1:0] line_word;
  logic [31:0]       insn;

  // beats are staged one cycle before they reach the banks
  // index stays put since the cpu holds its address until the pulse
  always_ff @(posedge clk) begin
    wr_en   <= beat_wen_i;
    wr_beat <= beat_i;
    wr_cnt  <= beat_cnt_i;
  end

  // even beats fill the low half of a bank word, odd beats the high half
  assign wr_mask = wr_cnt[0] ? {{XLEN{1'b1}}, {XLEN{1'b0}}}
                             : {{XLEN{1'b0}}, {XLEN{1'b1}}};

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_addr_o[b]  = index_i;
      bank_wen_o[b]   = wr_en;
      bank_wmask_o[b] = wr_mask;
      bank_wdata_o[b] = {wr_beat, wr_beat};           // mask picks the half
      bank_cen_o[b]   = !wr_en || (wr_cnt[2:1] == 2'(b)); // beat k -> bank k/2
    end
  end

  // bank by offset[5:4], 32-bit word by offset[3:2]
  assign line_word = bank_rdata_i[blk_ofs_i[5:4]];
  assign insn      = line_word[blk_ofs_i[3:2]*32 +: 32];
  assign rdata_o   = {{(XLEN-32){1'b0}}, insn};

endmodule

//--- rtl/icache_ctrl.sv
module icache_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                         fetch_valid_i,
  input  logic                         fencei_i,
  input  logic                         hit_i,
  input  logic                         ram_rdata_ready_i,
  input  logic [icache_pkg::XLEN-1:0]   ram_rdata_i,
  output logic                         fetch_rdata_valid_o,
  output logic                         src_uncache_o,
  output logic [icache_pkg::XLEN-1:0]   uncache_rdata_o,
  output logic                         tag_wen_o,
  output logic                         beat_wen_o,
  output logic [2:0]                   beat_cnt_o,
  output logic [icache_pkg::OFS_W-1:0]  blk_ofs_o,
  output logic [icache_pkg::ADDR_W-1:0] ram_raddr_o,
  output logic                         ram_raddr_valid_o,
  output logic [3:0]                   ram_rsize_o,
  output logic [7:0]                   ram_rlen_o
);
  import icache_pkg::*;

  localparam logic [1:0] S_START   = 2'd0;
  localparam logic [1:0] S_IDLE    = 2'd1;
  localparam logic [1:0] S_MISS    = 2'd2;
  localparam logic [1:0] S_UNCACHE = 2'd3;

  logic [1:0] state;
  logic       uncache;
  logic       accept;
  logic       start_miss;
  logic       start_unc;
  logic       handshake;
  logic       last_beat;

  assign uncache    = fetch_addr_i < UNCACHE_LIMIT;
  // sram is single port, so nothing new while the tag write is pending
  assign accept     = (state == S_IDLE) && fetch_valid_i && !tag_wen_o && !fencei_i;
  assign start_unc  = accept && uncache;
  assign start_miss = accept && !uncache && !hit_i;
  assign handshake  = ram_raddr_valid_o && ram_rdata_ready_i;
  assign last_beat  = beat_cnt_o == 3'(LINE_BEATS - 1);
  assign beat_wen_o = handshake && (state == S_MISS); // refill beats only

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state               <= S_START;
      fetch_rdata_valid_o <= 1'b0;
      tag_wen_o           <= 1'b0;
      ram_raddr_valid_o   <= 1'b0;
      src_uncache_o       <= 1'b0;
      beat_cnt_o          <= '0;
    end else begin
      fetch_rdata_valid_o <= 1'b0; // one-cycle pulse
      tag_wen_o           <= 1'b0;
      case (state)
        S_START: begin
          state <= S_IDLE;
        end
        S_IDLE: begin
          if (start_unc) begin
            state             <= S_UNCACHE;
            ram_raddr_valid_o <= 1'b1;
            src_uncache_o     <= 1'b1;
          end else if (start_miss) begin
            state             <= S_MISS;
            ram_raddr_valid_o <= 1'b1;
            beat_cnt_o        <= '0;
          end else if (accept) begin
            // hit, sram read is already under way
            fetch_rdata_valid_o <= 1'b1;
            src_uncache_o       <= 1'b0;
          end
        end
        S_MISS: begin
          if (handshake) begin
            beat_cnt_o <= beat_cnt_o + 3'd1;
            if (last_beat) begin
              state             <= S_IDLE; // re-lookup after the tag write
              ram_raddr_valid_o <= 1'b0;
              tag_wen_o         <= 1'b1;
            end
          end
        end
        S_UNCACHE: begin
          if (handshake) begin
            state               <= S_IDLE;
            ram_raddr_valid_o   <= 1'b0;
            fetch_rdata_valid_o <= 1'b1;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // request and data payload
  always_ff @(posedge clk) begin
    if (accept) begin
      blk_ofs_o <= fetch_addr_i[OFS_W-1:0];
    end
    if (start_unc) begin
      ram_raddr_o <= fetch_addr_i; // unaligned, single word
      ram_rsize_o <= RSIZE_WORD;
      ram_rlen_o  <= '0;
    end else if (start_miss) begin
      ram_raddr_o <= {fetch_addr_i[ADDR_W-1:OFS_W], {OFS_W{1'b0}}}; // line aligned
      ram_rsize_o <= RSIZE_LINE;
      ram_rlen_o  <= RLEN_LINE;
    end
    if ((state == S_UNCACHE) && handshake) begin
      // bit 2 selects the half of the beat holding the instruction
      uncache_rdata_o <= ram_raddr_o[2] ? {32'b0, ram_rdata_i[63:32]}
                                        : {32'b0, ram_rdata_i[31:0]};
    end
  end

endmodule

//--- rtl/icache_top.sv
module icache_top (
  input  logic                         clk,
  input  logic                         rst,
  // cpu fetch port
  input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                         fetch_valid_i,
  input  logic                         fencei_i,
  output logic [icache_pkg::XLEN-1:0]   fetch_rdata_o,
  output logic                         fetch_rdata_valid_o,
  // memory read bus
  output logic [icache_pkg::ADDR_W-1:0] ram_raddr_o,
  output logic                         ram_raddr_valid_o,
  output logic [3:0]                   ram_rsize_o,
  output logic [7:0]                   ram_rlen_o,
  input  logic                         ram_rdata_ready_i,
  input  logic [icache_pkg::XLEN-1:0]   ram_rdata_i
);
  import icache_pkg::*;

  logic [TAG_W-1:0] line_tag;
  logic [IDX_W-1:0] line_idx;
  logic             hit;
  logic             tag_wen;
  logic             beat_wen;
  logic [2:0]       beat_cnt;
  logic [OFS_W-1:0] blk_ofs;
  logic             src_uncache;
  logic [XLEN-1:0]  uncache_rdata;
  logic [XLEN-1:0]  cache_rdata;

  logic [NUM_BANKS-1:0][IDX_W-1:0]  bank_addr;
  logic [NUM_BANKS-1:0]             bank_cen;
  logic [NUM_BANKS-1:0]             bank_wen;
  logic [NUM_BANKS-1:0][BANK_W-1:0] bank_wmask;
  logic [NUM_BANKS-1:0][BANK_W-1:0] bank_wdata;
  logic [NUM_BANKS-1:0][BANK_W-1:0] bank_rdata;

  assign line_tag = fetch_addr_i[ADDR_W-1 -: TAG_W];
  assign line_idx = fetch_addr_i[OFS_W +: IDX_W];

  icache_ctrl u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .fencei_i            (fencei_i),
    .hit_i               (hit),
    .ram_rdata_ready_i   (ram_rdata_ready_i),
    .ram_rdata_i         (ram_rdata_i),
    .fetch_rdata_valid_o (fetch_rdata_valid_o),
    .src_uncache_o       (src_uncache),
    .uncache_rdata_o     (uncache_rdata),
    .tag_wen_o           (tag_wen),
    .beat_wen_o          (beat_wen),
    .beat_cnt_o          (beat_cnt),
    .blk_ofs_o           (blk_ofs),
    .ram_raddr_o         (ram_raddr_o),
    .ram_raddr_valid_o   (ram_raddr_valid_o),
    .ram_rsize_o         (ram_rsize_o),
    .ram_rlen_o          (ram_rlen_o)
  );

  icache_tag u_tag (
    .clk           (clk),
    .rst           (rst),
    .tag_i         (line_tag),
    .index_i       (line_idx),
    .write_valid_i (tag_wen),
    .fencei_i      (fencei_i),
    .hit_o         (hit)
  );

  icache_data u_data (
    .clk          (clk),
    .index_i      (line_idx),
    .blk_ofs_i    (blk_ofs),
    .beat_i       (ram_rdata_i),
    .beat_cnt_i   (beat_cnt),
    .beat_wen_i   (beat_wen),
    .rdata_o      (cache_rdata),
    .bank_addr_o  (bank_addr),
    .bank_cen_o   (bank_cen),
    .bank_wen_o   (bank_wen),
    .bank_wmask_o (bank_wmask),
    .bank_wdata_o (bank_wdata),
    .bank_rdata_i (bank_rdata)
  );

  // bank0 .. bank3, 16 bytes of each line apiece
  for (genvar b = 0; b < NUM_BANKS; b++) begin : bank
    icache_sram u_sram (
      .clk     (clk),
      .addr_i  (bank_addr[b]),
      .cen_i   (bank_cen[b]),
      .wen_i   (bank_wen[b]),
      .wmask_i (bank_wmask[b]),
      .wdata_i (bank_wdata[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  assign fetch_rdata_o = src_uncache ? uncache_rdata : cache_rdata; // last completed source

endmodule

//--- tb/tb_mem_model.sv
module tb_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] raddr_i,
  input  logic        raddr_valid_i,
  input  logic [3:0]  rsize_i,
  input  logic [7:0]  rlen_i,
  output logic        rdata_ready_o,
  output logic [63:0] rdata_o,
  output int          xfer_cnt_o,
  output logic [31:0] rec_addr_o,
  output logic [3:0]  rec_size_o,
  output logic [7:0]  rec_len_o,
  output int          rec_beats_o
);

  localparam logic [31:0] SEED = 32'h133c_fde0;

  logic valid_q;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // one word per 8-byte address
  function automatic logic [63:0] mem_word(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:3], 3'b000};
    return {w ^ 32'hdead_beef, (w * 32'h9e37_79b1) ^ 32'h0f1e_2d3c};
  endfunction

  // transfer bookkeeping, sampled on the same edge as the dut
  always @(posedge clk) begin
    if (rst) begin
      valid_q     <= 1'b0;
      xfer_cnt_o  <= 0;
      rec_beats_o <= 0;
    end else begin
      valid_q <= raddr_valid_i;
      if (raddr_valid_i && !valid_q) begin // new request
        xfer_cnt_o  <= xfer_cnt_o + 1;
        rec_addr_o  <= raddr_i;
        rec_size_o  <= rsize_i;
        rec_len_o   <= rlen_i;
        rec_beats_o <= rdata_ready_o ? 1 : 0;
      end else if (raddr_valid_i && rdata_ready_o) begin
        rec_beats_o <= rec_beats_o + 1;
      end
    end
  end

  // ready pulses with 0 to 3 idle cycles in front of each
  initial begin
    logic [31:0] state;
    int          idx;
    int          gap;
    state         = SEED;
    idx           = 0;
    gap           = 0;
    rdata_ready_o = 1'b0;
    rdata_o       = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rdata_ready_o) begin
        idx++; // beat taken at the edge just passed
      end
      rdata_ready_o = 1'b0;
      if (rst || !raddr_valid_i) begin
        idx = 0;
      end else if (gap > 0) begin
        gap--;
      end else begin
        rdata_ready_o = 1'b1;
        rdata_o       = mem_word({raddr_i[31:3], 3'b000} + 32'(idx * 8));
        state         = lcg_next(state);
        gap           = int'(state[31:30]);
      end
    end
  end

endmodule

//--- tb/tb_icache.sv
module tb_icache;
  import icache_pkg::*;

  localparam int WAIT_LIMIT = 200; // well above a burst with maximum gaps
  localparam int NUM_RANDOM = 400;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] fetch_addr;
  logic              fetch_valid;
  logic              fencei;
  logic [XLEN-1:0]   fetch_rdata;
  logic              fetch_rdata_valid;
  logic [ADDR_W-1:0] ram_raddr;
  logic              ram_raddr_valid;
  logic [3:0]        ram_rsize;
  logic [7:0]        ram_rlen;
  logic              ram_rdata_ready;
  logic [XLEN-1:0]   ram_rdata;

  // what the memory model saw on the bus
  int                xfer_cnt;
  logic [ADDR_W-1:0] rec_addr;
  logic [3:0]        rec_size;
  logic [7:0]        rec_len;
  int                rec_beats;

  // reference tag and valid arrays
  logic [TAG_W-1:0]  model_tag [NUM_LINES];
  logic              model_valid [NUM_LINES];
  logic [31:0]       seed;

  icache_top dut (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr),
    .fetch_valid_i       (fetch_valid),
    .fencei_i            (fencei),
    .fetch_rdata_o       (fetch_rdata),
    .fetch_rdata_valid_o (fetch_rdata_valid),
    .ram_raddr_o         (ram_raddr),
    .ram_raddr_valid_o   (ram_raddr_valid),
    .ram_rsize_o         (ram_rsize),
    .ram_rlen_o          (ram_rlen),
    .ram_rdata_ready_i   (ram_rdata_ready),
    .ram_rdata_i         (ram_rdata)
  );

  tb_mem_model mem_model (
    .clk           (clk),
    .rst           (rst),
    .raddr_i       (ram_raddr),
    .raddr_valid_i (ram_raddr_valid),
    .rsize_i       (ram_rsize),
    .rlen_i        (ram_rlen),
    .rdata_ready_o (ram_rdata_ready),
    .rdata_o       (ram_rdata),
    .xfer_cnt_o    (xfer_cnt),
    .rec_addr_o    (rec_addr),
    .rec_size_o    (rec_size),
    .rec_len_o     (rec_len),
    .rec_beats_o   (rec_beats)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // same rule as the memory contents, one word per 8-byte address
  function automatic logic [63:0] expected_word(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:3], 3'b000};
    return {w ^ 32'hdead_beef, (w * 32'h9e37_79b1) ^ 32'h0f1e_2d3c};
  endfunction

  // line bases: conflicting tags on indices 3 and 42, plus two uncached lines
  function automatic logic [ADDR_W-1:0] pool_line(input logic [2:0] sel);
    case (sel)
      3'd0:    return 32'h8000_00c0;
      3'd1:    return 32'h8000_10c0;
      3'd2:    return 32'h9abc_d0c0;
      3'd3:    return 32'h8000_0a80;
      3'd4:    return 32'h8765_4a80;
      3'd5:    return 32'hffff_f440;
      3'd6:    return 32'h0000_1000;
      default: return 32'h7fff_ffc0;
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] pick_addr(input logic [31:0] r);
    return pool_line(r[18:16]) | {26'b0, r[22:19], 2'b00}; // random word in the line
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic wait_rdata_valid(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen) begin
      @(posedge clk);
      #1;
      cycles++;
      seen = fetch_rdata_valid;
      if (!seen && cycles >= WAIT_LIMIT) begin
        fail_run("timeout: no fetch_rdata_valid_o pulse for a pending fetch");
      end
    end
  endtask

  // leaves the address up, so a following call runs back to back
  task automatic fetch_one(input logic [ADDR_W-1:0] addr);
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic             unc;
    logic             hit;
    logic [63:0]      word;
    logic [63:0]      exp_data;
    int               n_before;
    int               cycles;
    tag      = addr[ADDR_W-1 -: TAG_W];
    idx      = addr[OFS_W +: IDX_W];
    unc      = addr < 32'h8000_0000;
    hit      = !unc && model_valid[idx] && (model_tag[idx] == tag);
    word     = expected_word(addr);
    exp_data = {32'h0, addr[2] ? word[63:32] : word[31:0]};
    n_before = xfer_cnt;
    fetch_addr  = addr;
    fetch_valid = 1'b1;
    wait_rdata_valid(cycles);
    compare("fetch_rdata_o", fetch_rdata, exp_data);
    if (hit) begin
      compare("hit latency", 64'(cycles), 64'd1);
      compare("bus transfers", 64'(xfer_cnt - n_before), 64'd0);
    end else begin
      compare("bus transfers", 64'(xfer_cnt - n_before), 64'd1);
      compare("ram_raddr_o", 64'(rec_addr), unc ? 64'(addr) : 64'({addr[31:6], 6'b0}));
      compare("ram_rsize_o", 64'(rec_size), unc ? 64'h4 : 64'h8);
      compare("ram_rlen_o", 64'(rec_len), unc ? 64'd0 : 64'd7);
      compare("beat count", 64'(rec_beats), unc ? 64'd1 : 64'd8);
    end
    if (!unc && !hit) begin
      model_valid[idx] = 1'b1; // line now resident
      model_tag[idx]   = tag;
    end
  endtask

  task automatic idle_for(input int n);
    fetch_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
      compare("fetch_rdata_valid_o", 64'(fetch_rdata_valid), 64'd0);
      compare("ram_raddr_valid_o", 64'(ram_raddr_valid), 64'd0);
    end
  endtask

  task automatic flush_all();
    fetch_valid = 1'b0;
    fencei      = 1'b1;
    @(posedge clk);
    #1;
    fencei = 1'b0;
    for (int i = 0; i < NUM_LINES; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  initial begin
    rst         = 1'b1;
    fetch_addr  = '0;
    fetch_valid = 1'b0;
    fencei      = 1'b0;
    seed        = 32'h133c_fde0;
    for (int i = 0; i < NUM_LINES; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    idle_for(4);              // quiet after reset
    fetch_one(32'h8000_00c4); // cold miss
    fetch_one(32'h8000_00c8); // hits, back to back
    fetch_one(32'h8000_00fc);
    fetch_one(32'h8000_00c0);
    fetch_one(32'h8000_10c4); // same index, other tag
    fetch_one(32'h8000_00c4); // evicted, so refilled
    fetch_one(32'h0000_1004); // uncached upper half
    fetch_one(32'h0000_1004);
    fetch_one(32'h7fff_ffc0);
    idle_for(2);
    flush_all();
    fetch_one(32'h8000_00c4);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      seed = lcg_next(seed);
      if (seed[31:28] == 4'd0) begin
        flush_all();
      end else if (seed[27:25] == 3'd0) begin
        idle_for(1 + int'(seed[24:23]));
      end
      fetch_one(pick_addr(seed));
    end
    idle_for(2);

    $display("TEST OK");
    $finish;
  end

endmodule

//--- sources.f
rtl/icache_pkg.sv
rtl/icache_tag.sv
rtl/icache_sram.sv
rtl/icache_data.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/tb_mem_model.sv
tb/tb_icache.sv

//--- run.sh
#!/bin/sh
# build the icache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_icache -f sources.f

out=$(./obj_dir/Vtb_icache 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "TEST OK"
